/* project.f */
verilog/rename_pkg.sv
verilog/inst_queue.sv
verilog/free_list.sv
verilog/rename_table.sv
verilog/rob_tag_counter.sv
verilog/dispatch_ctrl.sv
verilog/entry_builder.sv
verilog/rename_dispatch_top.sv
tb/rename_dispatch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the rename and dispatch testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f project.f \
    --top-module rename_dispatch_tb --Mdir "$OBJ" > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Build failed with status $status"
    exit 1
fi

"./$OBJ/Vrename_dispatch_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0

/* tb/rename_dispatch_tb.sv */
// Plays fetch, reservation station and ROB; fetch pushes every other cycle and never while full
`timescale 1ns/1ps

module rename_dispatch_tb
    import rename_pkg::*;
;
    localparam int IQ_DEPTH  = 8;
    localparam int ROB_DEPTH = 8;

    logic            clk;
    logic            rst;
    logic            fetch_valid;
    decoded_inst_t   fetch_inst;
    logic            iq_full;
    logic            rs_full;
    logic            wb_valid;
    phys_reg_t       wb_preg;
    logic            commit_valid;
    phys_reg_t       commit_old_prd;
    logic            commit_is_store;
    logic            dispatch_valid;
    dispatch_entry_t dispatch_entry;

    // Reference model state
    phys_reg_t       m_map [ARCH_REGS];
    logic [PHYS_REGS-1:0] m_ready;
    phys_reg_t       free_q [$];
    rob_tag_t        m_tag;
    int              rob_count;
    logic            store_wait;
    logic            rs_full_d;
    // Every pushed instruction and every dispatched entry, in program order
    decoded_inst_t   fetched [$];
    phys_reg_t       d_prd [$];
    phys_reg_t       d_old [$];
    logic            d_store [$];
    logic            d_ren [$];
    // Destinations as the DUT handed them out
    phys_reg_t       a_prd [$];
    int              disp_count;
    int              wb_count;
    int              commit_count;

    // Stimulus knobs
    logic            wb_en;
    logic            rs_random;
    int              commit_budget;
    logic [31:0]     lfsr;
    logic [31:0]     pc_next;
    int              errors;
    int              tests_run;
    int              tests_failed;
    logic            aborted;
    string           cur_test;

    rename_dispatch_top #(.IQ_DEPTH(IQ_DEPTH), .ROB_DEPTH(ROB_DEPTH)) DUT (
        .clk(clk), .rst(rst), .fetch_valid(fetch_valid), .fetch_inst(fetch_inst),
        .iq_full(iq_full), .rs_full(rs_full), .wb_valid(wb_valid), .wb_preg(wb_preg),
        .commit_valid(commit_valid), .commit_old_prd(commit_old_prd),
        .commit_is_store(commit_is_store), .dispatch_valid(dispatch_valid),
        .dispatch_entry(dispatch_entry)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic check_val(input string field, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            errors++;
            $display("FAIL %s %s expected %0d actual %0d", cur_test, field, exp, act);
        end
    endtask

    task automatic report_rule(input string what);
        errors++;
        $display("ERROR in %s: %s", cur_test, what);
    endtask

    // Reference model, checker, writeback unit and in-order ROB commit
    always @(posedge clk) begin
        decoded_inst_t ei;
        phys_reg_t     e1;
        phys_reg_t     e2;
        phys_reg_t     eo;
        phys_reg_t     ep;
        logic          ren;
        ren = 1'b0;
        if (rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                m_map[i] = phys_reg_t'(i);
            end
            m_ready = '1;
            free_q.delete();
            for (int i = ARCH_REGS; i < PHYS_REGS; i++) begin
                free_q.push_back(phys_reg_t'(i));
            end
            m_tag = '0;
            rob_count = 0;
            store_wait = 1'b0;
            rs_full_d = 1'b0;
            wb_valid <= 1'b0;
            commit_valid <= 1'b0;
            rs_full <= 1'b0;
        end else begin
            if (dispatch_valid) begin
                assert (!rs_full_d) else report_rule("dispatch after a cycle with rs_full high");
                assert (rob_count < ROB_DEPTH) else report_rule("dispatch with the ROB full");
                assert (!store_wait) else report_rule("dispatch before the store committed");
                assert (disp_count < fetched.size()) else report_rule("dispatch of nothing");
                ei = fetched[disp_count];
                ep = free_q.pop_front();
                e1 = m_map[ei.rs1];
                e2 = m_map[ei.rs2];
                ren = ei.has_rd && (ei.rd != 0);
                eo = ren ? m_map[ei.rd] : ep;
                assert (dispatch_entry.inst == ei) else report_rule("instruction out of order");
                check_val("pc", ei.pc, dispatch_entry.inst.pc);
                check_val("rob_tag", 32'(m_tag), 32'(dispatch_entry.rob_tag));
                check_val("prs1", 32'(e1), 32'(dispatch_entry.prs1));
                check_val("prs2", 32'(e2), 32'(dispatch_entry.prs2));
                check_val("prd", 32'(ep), 32'(dispatch_entry.prd));
                check_val("old_prd", 32'(eo), 32'(dispatch_entry.old_prd));
                check_val("src1_ready", 32'(!ei.uses_rs1 || ei.rs1 == 0 || m_ready[e1]
                          || (wb_valid && wb_preg == e1)), 32'(dispatch_entry.src1_ready));
                check_val("src2_ready", 32'(!ei.uses_rs2 || ei.rs2 == 0 || m_ready[e2]
                          || (wb_valid && wb_preg == e2)), 32'(dispatch_entry.src2_ready));
                d_prd.push_back(ep);
                d_old.push_back(eo);
                d_store.push_back(ei.is_store);
                d_ren.push_back(ren);
                a_prd.push_back(dispatch_entry.prd);
                if (ren) begin
                    m_map[ei.rd] = ep;
                end
                m_tag = (m_tag == ROB_DEPTH - 1) ? '0 : m_tag + 1'b1;
                disp_count++;
                rob_count++;
                if (ei.is_store) begin
                    store_wait = 1'b1;
                end
            end
            if (wb_valid) begin
                m_ready[wb_preg] = 1'b1;
            end
            // Clear of a new destination wins over a writeback
            if (ren) begin
                m_ready[ep] = 1'b0;
            end
            if (commit_valid) begin
                free_q.push_back(commit_old_prd);
                rob_count--;
                if (commit_is_store) begin
                    store_wait = 1'b0;
                end
            end
            rs_full_d = rs_full;
            // Writeback in dispatch order
            if (wb_en && wb_count < disp_count && rand_bits(1)) begin
                wb_valid <= d_ren[wb_count];
                wb_preg  <= d_prd[wb_count];
                wb_count++;
            end else begin
                wb_valid <= 1'b0;
            end
            // Commit only what has written back
            if (commit_budget > 0 && commit_count < wb_count && rand_bits(1)) begin
                commit_valid    <= 1'b1;
                commit_old_prd  <= d_old[commit_count];
                commit_is_store <= d_store[commit_count];
                commit_count++;
                commit_budget--;
            end else begin
                commit_valid <= 1'b0;
            end
            rs_full <= rs_random ? 1'(rand_bits(1)) : 1'b0;
        end
    end

    function automatic decoded_inst_t make_inst(input arch_reg_t rd, input arch_reg_t rs1,
                                                input arch_reg_t rs2, input logic has_rd,
                                                input logic st);
        decoded_inst_t i;
        i = '0;
        i.inst     = rand_bits(32);
        i.rd       = rd;
        i.rs1      = rs1;
        i.rs2      = rs2;
        i.has_rd   = has_rd;
        i.uses_rs1 = (rs1 != 0) || st;
        i.uses_rs2 = (rs2 != 0);
        i.is_store = st;
        i.wmask    = st ? 4'hf : 4'h0;
        return i;
    endfunction

    task automatic push_inst(input decoded_inst_t i);
        int n;
        n = 0;
        while (iq_full && n < 200) begin
            @(posedge clk);
            n++;
        end
        if (iq_full) begin
            report_rule("instruction queue never left full");
            aborted = 1'b1;
        end else begin
            i.pc = pc_next;
            pc_next += 4;
            fetched.push_back(i);
            fetch_valid <= 1'b1;
            fetch_inst  <= i;
            @(posedge clk);
            fetch_valid <= 1'b0;
            @(posedge clk);
        end
    endtask

    task automatic wait_dispatched(input int target);
        int n;
        n = 0;
        while (disp_count < target && n < 500) begin
            @(posedge clk);
            n++;
        end
        if (disp_count < target) begin
            report_rule("timed out waiting for dispatches");
            aborted = 1'b1;
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while ((disp_count < fetched.size() || rob_count != 0) && n < 1000) begin
            @(posedge clk);
            n++;
        end
        if (disp_count < fetched.size() || rob_count != 0) begin
            report_rule("timed out waiting for the pipeline to drain");
            aborted = 1'b1;
        end
    endtask

    task automatic end_test(input int err_before);
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
        end
        $display("test %s: %s", cur_test, (errors == err_before) ? "ok" : "FAILED");
    endtask

    initial begin
        int e0;
        int base;
        lfsr = 32'hb2;
        {errors, tests_run, tests_failed, disp_count, wb_count, commit_count} = '0;
        aborted = 1'b0;
        pc_next = 32'h1000;
        rst = 1'b1;
        fetch_valid = 1'b0;
        fetch_inst = '0;
        rs_full = 1'b0;
        wb_valid = 1'b0;
        wb_preg = '0;
        commit_valid = 1'b0;
        commit_old_prd = '0;
        commit_is_store = 1'b0;
        wb_en = 1'b1;
        rs_random = 1'b0;
        commit_budget = 1000000;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        cur_test = "reset_map";
        e0 = errors;
        for (int i = 1; i <= 4; i++) begin
            push_inst(make_inst(arch_reg_t'(i), arch_reg_t'(i + 8), arch_reg_t'(i + 12), 1, 0));
        end
        wait_dispatched(4);
        // Free list hands out p32 upward after reset
        for (int i = 0; i < 4; i++) begin
            check_val("prd after reset", 32 + i, 32'(a_prd[i]));
        end
        wait_drained();
        end_test(e0);

        cur_test = "raw_dependency";
        e0 = errors;
        base = disp_count;
        wb_en = 1'b0;
        push_inst(make_inst(7, 0, 0, 1, 0));
        push_inst(make_inst(9, 7, 0, 1, 0));
        wait_dispatched(base + 2);
        wb_en = 1'b1;
        push_inst(make_inst(10, 7, 9, 1, 0));
        push_inst(make_inst(11, 10, 0, 1, 0));
        wait_drained();
        end_test(e0);

        cur_test = "back_pressure";
        e0 = errors;
        rs_random = 1'b1;
        for (int i = 0; i < 24; i++) begin
            push_inst(make_inst(arch_reg_t'(rand_bits(5)), arch_reg_t'(rand_bits(5)),
                                arch_reg_t'(rand_bits(5)), rand_bits(2) != 0, 0));
        end
        wait_drained();
        rs_random = 1'b0;
        end_test(e0);

        cur_test = "rob_full";
        e0 = errors;
        base = disp_count;
        commit_budget = 0;
        // ROB fills first, then the queue behind it
        for (int i = 0; i < ROB_DEPTH + IQ_DEPTH; i++) begin
            push_inst(make_inst(arch_reg_t'(i + 1), 0, 0, 1, 0));
        end
        wait_dispatched(base + ROB_DEPTH);
        repeat (20) @(posedge clk);
        check_val("dispatched while full", base + ROB_DEPTH, disp_count);
        check_val("iq_full while blocked", 1, 32'(iq_full));
        commit_budget = 1;
        wait_dispatched(base + ROB_DEPTH + 1);
        repeat (20) @(posedge clk);
        check_val("dispatched after one commit", base + ROB_DEPTH + 1, disp_count);
        check_val("iq_full after one pop", 0, 32'(iq_full));
        commit_budget = 1000000;
        wait_drained();
        end_test(e0);

        cur_test = "store_stall";
        e0 = errors;
        push_inst(make_inst(0, 3, 4, 0, 1));
        for (int i = 0; i < 3; i++) begin
            push_inst(make_inst(arch_reg_t'(i + 5), 3, 0, 1, 0));
        end
        wait_drained();
        end_test(e0);

        cur_test = "recycling";
        e0 = errors;
        push_inst(make_inst(0, 1, 2, 1, 0));
        for (int i = 0; i < 40; i++) begin
            push_inst(make_inst(arch_reg_t'(rand_bits(5)), arch_reg_t'(rand_bits(5)),
                                arch_reg_t'(rand_bits(5)), 1, 0));
        end
        wait_drained();
        end_test(e0);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && !aborted) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verilog/dispatch_ctrl.sv */
// One store in flight at a time; dispatch resumes only on a store commit
`timescale 1ns/1ps

module dispatch_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic iq_empty,
    input  logic fl_empty,
    input  logic rob_full,
    input  logic rs_full,
    input  logic cur_is_store,
    input  logic commit_store,
    output logic pop,
    output logic dispatch_valid
);

    typedef enum logic {
        RUN,
        STORE_WAIT
    } dispatch_state_t;

    dispatch_state_t state;
    dispatch_state_t state_next;
    logic            store_out;

    // A store leaves this cycle
    assign store_out = dispatch_valid && cur_is_store;

    // Pop both queues together when every resource is there
    always_comb begin
        pop = !iq_empty && !fl_empty && !rs_full && !rob_full;
        // Nothing may follow a store until it commits
        if (state == STORE_WAIT || store_out) begin
            pop = 1'b0;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            RUN: begin
                if (store_out) begin
                    state_next = STORE_WAIT;
                end
            end
            STORE_WAIT: begin
                if (commit_store) begin
                    state_next = RUN;
                end
            end
            default: begin
                state_next = RUN;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= RUN;
            dispatch_valid <= 1'b0;
        end else begin
            state <= state_next;
            // Queue heads hold the popped values one cycle later
            dispatch_valid <= pop;
        end
    end

endmodule

/* verilog/entry_builder.sv */
// Purely combinational; output is meaningful only while dispatch_valid is high
`timescale 1ns/1ps

module entry_builder
    import rename_pkg::*;
(
    input  decoded_inst_t   inst,
    input  rob_tag_t        tag,
    input  phys_reg_t       prs1,
    input  phys_reg_t       prs2,
    input  phys_reg_t       old_prd,
    input  phys_reg_t       prd,
    input  logic            rs1_ready,
    input  logic            rs2_ready,
    input  logic            wb_valid,
    input  phys_reg_t       wb_preg,
    output dispatch_entry_t entry
);

    logic renames;
    logic wb_hit1;
    logic wb_hit2;

    // Only a real destination changes the map
    assign renames = inst.has_rd && (inst.rd != '0);

    // Writeback in this cycle has not reached the ready table yet
    assign wb_hit1 = wb_valid && (wb_preg == prs1);
    assign wb_hit2 = wb_valid && (wb_preg == prs2);

    always_comb begin
        entry.inst    = inst;
        entry.rob_tag = tag;
        entry.prs1    = prs1;
        entry.prs2    = prs2;
        entry.prd     = prd;

        // Without a rename the popped register itself is freed at commit
        entry.old_prd = renames ? old_prd : prd;

        // Unused sources and x0 never wait
        entry.src1_ready = !inst.uses_rs1 || (inst.rs1 == '0) || rs1_ready || wb_hit1;
        entry.src2_ready = !inst.uses_rs2 || (inst.rs2 == '0) || rs2_ready || wb_hit2;
    end

endmodule

/* verilog/free_list.sv */
// Holds p32..p63 after reset; releases beyond capacity are dropped, head valid after a pop
`timescale 1ns/1ps

module free_list
    import rename_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      pop,
    output phys_reg_t head,
    input  logic      release_en,
    input  phys_reg_t release_preg,
    output logic      empty
);

    // Only the registers above the architectural set start free
    localparam int FL_DEPTH = PHYS_REGS - ARCH_REGS;
    localparam int PTR_W = $clog2(FL_DEPTH);
    localparam int CNT_W = $clog2(FL_DEPTH + 1);

    phys_reg_t        slots [FL_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;
    logic             do_release;

    assign empty      = (count == '0);
    assign do_pop     = pop && !empty;
    assign do_release = release_en && (count != CNT_W'(FL_DEPTH));

    always_ff @(posedge clk) begin
        if (rst) begin
            // Buffer starts full so the write pointer wraps back to zero
            for (int i = 0; i < FL_DEPTH; i++) begin
                slots[i] <= phys_reg_t'(ARCH_REGS + i);
            end
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= CNT_W'(FL_DEPTH);
        end else begin
            // Committed register goes back at the tail
            if (do_release) begin
                slots[wr_ptr] <= release_preg;
                wr_ptr        <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_release && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_release) begin
                count <= count - 1'b1;
            end
        end
    end

    // Head register follows the pop, like the instruction queue
    always_ff @(posedge clk) begin
        if (do_pop) begin
            head <= slots[rd_ptr];
        end
    end

endmodule

/* verilog/inst_queue.sv */
// Pushes while full and pops while empty are dropped; head is valid the cycle after a pop
`timescale 1ns/1ps

module inst_queue
    import rename_pkg::*;
#(
    parameter int IQ_DEPTH = 8
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          push,
    input  decoded_inst_t push_inst,
    input  logic          pop,
    output decoded_inst_t head,
    output logic          empty,
    output logic          full
);

    localparam int PTR_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(IQ_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(IQ_DEPTH - 1);

    // Instruction storage, no reset
    decoded_inst_t    slots [IQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(IQ_DEPTH));

    // Ignore requests that would break the buffer
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            // Push and pop together keep the count
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage write and registered head
    always_ff @(posedge clk) begin
        if (do_push) begin
            slots[wr_ptr] <= push_inst;
        end
        // Popped instruction presented next cycle
        if (do_pop) begin
            head <= slots[rd_ptr];
        end
    end

endmodule

/* verilog/rename_dispatch_top.sv */
// Single-issue rename and dispatch; fetch must not push while iq_full is high
`timescale 1ns/1ps

module rename_dispatch_top
    import rename_pkg::*;
#(
    parameter int IQ_DEPTH  = 8,
    parameter int ROB_DEPTH = 8
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            fetch_valid,
    input  decoded_inst_t   fetch_inst,
    output logic            iq_full,
    input  logic            rs_full,
    input  logic            wb_valid,
    input  phys_reg_t       wb_preg,
    input  logic            commit_valid,
    input  phys_reg_t       commit_old_prd,
    input  logic            commit_is_store,
    output logic            dispatch_valid,
    output dispatch_entry_t dispatch_entry
);

    decoded_inst_t iq_head;
    logic          iq_empty;
    phys_reg_t     fl_head;
    logic          fl_empty;
    logic          pop;
    phys_reg_t     prs1;
    phys_reg_t     prs2;
    phys_reg_t     old_prd;
    logic          rs1_ready;
    logic          rs2_ready;
    rob_tag_t      rob_tag;
    logic          rob_full;

    // Decoded instructions waiting for dispatch
    inst_queue #(.IQ_DEPTH(IQ_DEPTH)) u_inst_queue (
        .clk(clk), .rst(rst),
        .push(fetch_valid), .push_inst(fetch_inst),
        .pop(pop), .head(iq_head), .empty(iq_empty), .full(iq_full)
    );

    // Popped in step with the instruction queue, refilled by commits
    free_list u_free_list (
        .clk(clk), .rst(rst), .pop(pop), .head(fl_head),
        .release_en(commit_valid), .release_preg(commit_old_prd), .empty(fl_empty)
    );

    // Map update happens at the end of the dispatch cycle
    rename_table u_rename_table (
        .clk(clk), .rst(rst),
        .rs1(iq_head.rs1), .rs2(iq_head.rs2), .rd(iq_head.rd),
        .prs1(prs1), .prs2(prs2), .old_prd(old_prd),
        .rs1_ready(rs1_ready), .rs2_ready(rs2_ready),
        .rename_en(dispatch_valid && iq_head.has_rd), .new_prd(fl_head),
        .wb_valid(wb_valid), .wb_preg(wb_preg)
    );

    rob_tag_counter #(.ROB_DEPTH(ROB_DEPTH)) u_rob_tag_counter (
        .clk(clk), .rst(rst), .alloc(dispatch_valid), .retire(commit_valid),
        .tag(rob_tag), .full(rob_full)
    );

    dispatch_ctrl u_dispatch_ctrl (
        .clk(clk), .rst(rst),
        .iq_empty(iq_empty), .fl_empty(fl_empty), .rob_full(rob_full), .rs_full(rs_full),
        .cur_is_store(iq_head.is_store), .commit_store(commit_valid && commit_is_store),
        .pop(pop), .dispatch_valid(dispatch_valid)
    );

    entry_builder u_entry_builder (
        .inst(iq_head), .tag(rob_tag),
        .prs1(prs1), .prs2(prs2), .old_prd(old_prd), .prd(fl_head),
        .rs1_ready(rs1_ready), .rs2_ready(rs2_ready),
        .wb_valid(wb_valid), .wb_preg(wb_preg), .entry(dispatch_entry)
    );

endmodule

/* verilog/rename_pkg.sv */
// Shared types for rename and dispatch; rob_tag_t must stay $clog2(ROB_DEPTH) bits wide
package rename_pkg;

    // Register file sizes
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;

    // Architectural register index, x0 to x31
    typedef logic [4:0] arch_reg_t;

    // Physical register index, p0 to p63
    typedef logic [5:0] phys_reg_t;

    // ROB tag, sized for the default ROB_DEPTH of 8
    // Widen this together with ROB_DEPTH in the top level
    typedef logic [2:0] rob_tag_t;

    // Decoded instruction as it leaves decode
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        arch_reg_t   rs1;
        arch_reg_t   rs2;
        arch_reg_t   rd;
        // Writes a destination register
        logic        has_rd;
        // Source operands actually read
        logic        uses_rs1;
        logic        uses_rs2;
        logic        is_store;
        // Byte enables of a store
        logic [3:0]  wmask;
    } decoded_inst_t;

    // Entry handed to the reservation station and the ROB
    typedef struct packed {
        decoded_inst_t inst;
        rob_tag_t      rob_tag;
        // Renamed sources
        phys_reg_t     prs1;
        phys_reg_t     prs2;
        // New destination and the mapping it replaces
        phys_reg_t     prd;
        // Freed at commit
        phys_reg_t     old_prd;
        logic          src1_ready;
        logic          src2_ready;
    } dispatch_entry_t;

endpackage

/* verilog/rename_table.sv */
// Reads are combinational and see state before this edge's rename; x0 always maps to p0
`timescale 1ns/1ps

module rename_table
    import rename_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  arch_reg_t rs1,
    input  arch_reg_t rs2,
    input  arch_reg_t rd,
    output phys_reg_t prs1,
    output phys_reg_t prs2,
    output phys_reg_t old_prd,
    output logic      rs1_ready,
    output logic      rs2_ready,
    input  logic      rename_en,
    input  phys_reg_t new_prd,
    input  logic      wb_valid,
    input  phys_reg_t wb_preg
);

    // Architectural to physical map
    phys_reg_t            map [ARCH_REGS];
    // One ready bit per physical register
    logic [PHYS_REGS-1:0] ready;
    logic                 do_rename;

    // Writes to x0 never change its mapping
    assign do_rename = rename_en && (rd != '0);

    // Current mappings for the head instruction
    assign prs1    = map[rs1];
    assign prs2    = map[rs2];
    assign old_prd = map[rd];

    // Ready bits of the mapped sources
    assign rs1_ready = ready[prs1];
    assign rs2_ready = ready[prs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity map, every register holds a value
            for (int i = 0; i < ARCH_REGS; i++) begin
                map[i] <= phys_reg_t'(i);
            end
            ready <= '1;
        end else begin
            // Writeback marks its register as produced
            if (wb_valid) begin
                ready[wb_preg] <= 1'b1;
            end
            // New destination is pending until its writeback
            // Placed last so the clear wins on the same index
            if (do_rename) begin
                map[rd]        <= new_prd;
                ready[new_prd] <= 1'b0;
            end
        end
    end

endmodule

/* verilog/rob_tag_counter.sv */
// Full looks ahead through this cycle's alloc and retire; tag wraps at ROB_DEPTH
`timescale 1ns/1ps

module rob_tag_counter
    import rename_pkg::*;
#(
    parameter int ROB_DEPTH = 8
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     alloc,
    input  logic     retire,
    output rob_tag_t tag,
    output logic     full
);

    localparam int CNT_W = $clog2(ROB_DEPTH + 1);
    localparam rob_tag_t LAST_TAG = rob_tag_t'(ROB_DEPTH - 1);

    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;

    // Occupancy after this edge
    always_comb begin
        count_next = count;
        if (alloc && !retire) begin
            count_next = count + 1'b1;
        end else if (retire && !alloc) begin
            count_next = count - 1'b1;
        end
    end

    // An instruction popped now dispatches next cycle, so judge on the next count
    assign full = (count_next == CNT_W'(ROB_DEPTH));

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            tag   <= '0;
        end else begin
            count <= count_next;
            if (alloc) begin
                tag <= (tag == LAST_TAG) ? '0 : tag + 1'b1;
            end
        end
    end

endmodule
